/* src/axil_wr_slave.sv */
`default_nettype none

module axil_wr_slave #(
    parameter int MEM_DEPTH = 16,
    parameter int ADDR_W    = $clog2(MEM_DEPTH) + 3
) (
    input  logic                       S_AXI_ACLK,
    input  logic                       S_AXI_ARESETn,
    // write address channel
    input  logic [ADDR_W-1:0]          S_AXI_AWADDR,
    input  logic                       S_AXI_AWVALID,
    output logic                       S_AXI_AWREADY,
    // write data channel
    input  logic [frb_pkg::DATA_W-1:0] S_AXI_WDATA,
    input  logic [frb_pkg::STRB_W-1:0] S_AXI_WSTRB,
    input  logic                       S_AXI_WVALID,
    output logic                       S_AXI_WREADY,
    // write response channel
    output logic [1:0]                 S_AXI_BRESP,
    output logic                       S_AXI_BVALID,
    input  logic                       S_AXI_BREADY,
    // table write towards the memory
    frb_wr_if.source                   wr
);

    localparam int IDX_W  = $clog2(MEM_DEPTH);
    // word index width, one bit wider than the table needs
    localparam int WIDX_W = ADDR_W - 2;

    frb_pkg::wr_state_e state_q;
    frb_pkg::axi_resp_e resp_q;

    logic [IDX_W-1:0]           addr_q;
    logic [frb_pkg::DATA_W-1:0] data_q;
    logic [frb_pkg::STRB_W-1:0] strb_q;

    logic [WIDX_W-1:0] aw_idx;
    logic              in_range;
    logic              accept;

    // byte address to word index
    assign aw_idx   = S_AXI_AWADDR[ADDR_W-1:2];
    assign in_range = (aw_idx < WIDX_W'(MEM_DEPTH));

    // address and data only taken together
    assign accept = (state_q == frb_pkg::WR_IDLE) && S_AXI_AWVALID && S_AXI_WVALID;

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETn) begin
            state_q <= frb_pkg::WR_IDLE;
            resp_q  <= frb_pkg::OKAY;
        end else begin
            case (state_q)
                frb_pkg::WR_IDLE: begin
                    if (accept) begin
                        if (in_range) begin
                            resp_q  <= frb_pkg::OKAY;
                            state_q <= frb_pkg::WR_REQ;
                        end else begin
                            // out of range, answer without touching the table
                            resp_q  <= frb_pkg::SLVERR;
                            state_q <= frb_pkg::WR_RESP;
                        end
                    end
                end
                frb_pkg::WR_REQ: begin
                    if (wr.ack) begin
                        state_q <= frb_pkg::WR_WAIT_ACK_LOW;
                    end
                end
                frb_pkg::WR_WAIT_ACK_LOW: begin
                    if (!wr.ack) begin
                        state_q <= frb_pkg::WR_RESP;
                    end
                end
                frb_pkg::WR_RESP: begin
                    // hold BVALID until the master takes it
                    if (S_AXI_BREADY) begin
                        state_q <= frb_pkg::WR_IDLE;
                    end
                end
                default: begin
                    state_q <= frb_pkg::WR_IDLE;
                end
            endcase
        end
    end

    // latched write payload
    always_ff @(posedge S_AXI_ACLK) begin
        if (accept) begin
            addr_q <= aw_idx[IDX_W-1:0];
            data_q <= S_AXI_WDATA;
            strb_q <= S_AXI_WSTRB;
        end
    end

    assign S_AXI_AWREADY = (state_q == frb_pkg::WR_IDLE);
    assign S_AXI_WREADY  = (state_q == frb_pkg::WR_IDLE);
    assign S_AXI_BVALID  = (state_q == frb_pkg::WR_RESP);
    assign S_AXI_BRESP   = resp_q;

    assign wr.req  = (state_q == frb_pkg::WR_REQ);
    assign wr.addr = addr_q;
    assign wr.data = data_q;
    assign wr.strb = strb_q;

    // the memory only acknowledges a live request
    a_ack_needs_req : assert property (
        @(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETn)
        $rose(wr.ack) |-> $past(wr.req)
    );

endmodule

`default_nettype wire

/* src/burst_sequencer.sv */
`default_nettype none

module burst_sequencer #(
    parameter int MEM_DEPTH = 16
) (
    input  logic                         S_AXI_ACLK,
    input  logic                         S_AXI_ARESETn,
    input  logic                         en_frb,
    input  logic                         rst_frb,
    input  logic [frb_pkg::DATA_W-1:0]   rd_data,
    output logic [$clog2(MEM_DEPTH)-1:0] rd_addr,
    output logic                         fire,
    output logic                         frb_done
);

    localparam int               IDX_W    = $clog2(MEM_DEPTH);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(MEM_DEPTH - 1);

    frb_pkg::seq_state_e state_q;

    logic [IDX_W-1:0]           entry_q;
    logic [frb_pkg::DATA_W-1:0] period_q;
    logic [frb_pkg::DATA_W-1:0] count_q;
    logic                       load_period;

    // end of the current period
    assign fire = (state_q == frb_pkg::SEQ_COUNT) && en_frb && (count_q == period_q);

    // rd_data already holds the next entry when the period ends
    assign load_period = ((state_q == frb_pkg::SEQ_LOAD) && en_frb)
                       || (fire && (entry_q != LAST_IDX));

    assign frb_done = (state_q == frb_pkg::SEQ_DONE);

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETn || rst_frb) begin
            state_q <= frb_pkg::SEQ_IDLE;
            entry_q <= '0;
            rd_addr <= '0;
            count_q <= '0;
        end else begin
            case (state_q)
                frb_pkg::SEQ_IDLE: begin
                    // rd_addr sits at entry 0 here
                    if (en_frb) begin
                        state_q <= frb_pkg::SEQ_LOAD;
                    end
                end
                frb_pkg::SEQ_LOAD: begin
                    if (en_frb) begin
                        // prefetch entry 1 while entry 0 is counted
                        rd_addr <= rd_addr + 1'b1;
                        count_q <= '0;
                        state_q <= frb_pkg::SEQ_COUNT;
                    end
                end
                frb_pkg::SEQ_COUNT: begin
                    if (fire) begin
                        count_q <= '0;
                        if (entry_q == LAST_IDX) begin
                            state_q <= frb_pkg::SEQ_DONE;
                        end else begin
                            entry_q <= entry_q + 1'b1;
                            rd_addr <= rd_addr + 1'b1;
                        end
                    end else if (en_frb) begin
                        count_q <= count_q + 1'b1;
                    end
                end
                frb_pkg::SEQ_DONE: begin
                    // wait here for rst_frb
                    state_q <= frb_pkg::SEQ_DONE;
                end
                default: begin
                    state_q <= frb_pkg::SEQ_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (load_period) begin
            period_q <= rd_data;
        end
    end

endmodule

`default_nettype wire

/* src/frb_pkg.sv */
`default_nettype none

package frb_pkg;

    // bus and period widths
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // DAC codes, PULSE_LEVEL sits near +1 V on the converter
    localparam logic [15:0] PULSE_LEVEL = 16'h5FFF;
    localparam logic [15:0] IDLE_LEVEL  = 16'h0000;

    // write response codes
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

    // write slave states
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_REQ,
        WR_WAIT_ACK_LOW,
        WR_RESP
    } wr_state_e;

    // sequencer states
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_LOAD,
        SEQ_COUNT,
        SEQ_DONE
    } seq_state_e;

endpackage

`default_nettype wire

/* src/frb_trigger_top.sv */
`default_nettype none

module frb_trigger_top #(
    parameter int MEM_DEPTH = 16,
    parameter int ADDR_W    = $clog2(MEM_DEPTH) + 3
) (
    input  logic                       S_AXI_ACLK,
    input  logic                       S_AXI_ARESETn,
    // write address channel
    input  logic [ADDR_W-1:0]          S_AXI_AWADDR,
    input  logic [2:0]                 S_AXI_AWPROT,
    input  logic                       S_AXI_AWVALID,
    output logic                       S_AXI_AWREADY,
    // write data channel
    input  logic [frb_pkg::DATA_W-1:0] S_AXI_WDATA,
    input  logic [frb_pkg::STRB_W-1:0] S_AXI_WSTRB,
    input  logic                       S_AXI_WVALID,
    output logic                       S_AXI_WREADY,
    // write response channel
    output logic [1:0]                 S_AXI_BRESP,
    output logic                       S_AXI_BVALID,
    input  logic                       S_AXI_BREADY,
    // trigger control
    input  logic [frb_pkg::DATA_W-1:0] pulse_width,
    input  logic                       en_frb,
    input  logic                       rst_frb,
    output logic [15:0]                dac_out,
    output logic                       frb_done
);

    localparam int IDX_W = $clog2(MEM_DEPTH);

    logic [IDX_W-1:0]           rd_addr;
    logic [frb_pkg::DATA_W-1:0] rd_data;
    logic                       fire;

    // AWPROT is not decoded
    frb_wr_if #(.MEM_DEPTH(MEM_DEPTH)) wr_bus ();

    axil_wr_slave #(
        .MEM_DEPTH (MEM_DEPTH),
        .ADDR_W    (ADDR_W)
    ) i_axil_wr_slave (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETn (S_AXI_ARESETn),
        .S_AXI_AWADDR  (S_AXI_AWADDR),
        .S_AXI_AWVALID (S_AXI_AWVALID),
        .S_AXI_AWREADY (S_AXI_AWREADY),
        .S_AXI_WDATA   (S_AXI_WDATA),
        .S_AXI_WSTRB   (S_AXI_WSTRB),
        .S_AXI_WVALID  (S_AXI_WVALID),
        .S_AXI_WREADY  (S_AXI_WREADY),
        .S_AXI_BRESP   (S_AXI_BRESP),
        .S_AXI_BVALID  (S_AXI_BVALID),
        .S_AXI_BREADY  (S_AXI_BREADY),
        .wr            (wr_bus.source)
    );

    period_mem #(
        .MEM_DEPTH (MEM_DEPTH)
    ) i_period_mem (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETn (S_AXI_ARESETn),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .wr            (wr_bus.sink)
    );

    burst_sequencer #(
        .MEM_DEPTH (MEM_DEPTH)
    ) i_burst_sequencer (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETn (S_AXI_ARESETn),
        .en_frb        (en_frb),
        .rst_frb       (rst_frb),
        .rd_data       (rd_data),
        .rd_addr       (rd_addr),
        .fire          (fire),
        .frb_done      (frb_done)
    );

    pulse_shaper i_pulse_shaper (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETn (S_AXI_ARESETn),
        .rst_frb       (rst_frb),
        .fire          (fire),
        .pulse_width   (pulse_width),
        .dac_out       (dac_out)
    );

endmodule

`default_nettype wire

/* src/frb_wr_if.sv */
`default_nettype none

interface frb_wr_if #(
    parameter int MEM_DEPTH = 16
);

    localparam int IDX_W = $clog2(MEM_DEPTH);

    // four-phase handshake
    logic req;
    logic ack;

    // word index into the period table
    logic [IDX_W-1:0]           addr;
    logic [frb_pkg::DATA_W-1:0] data;
    logic [frb_pkg::STRB_W-1:0] strb;

    modport source (
        output req,
        output addr,
        output data,
        output strb,
        input  ack
    );

    modport sink (
        input  req,
        input  addr,
        input  data,
        input  strb,
        output ack
    );

endinterface

`default_nettype wire

/* src/period_mem.sv */
`default_nettype none

module period_mem #(
    parameter int MEM_DEPTH = 16
) (
    input  logic                         S_AXI_ACLK,
    input  logic                         S_AXI_ARESETn,
    // sequencer read port
    input  logic [$clog2(MEM_DEPTH)-1:0] rd_addr,
    output logic [frb_pkg::DATA_W-1:0]   rd_data,
    // table write from the slave
    frb_wr_if.sink                       wr
);

    logic [frb_pkg::DATA_W-1:0] mem [MEM_DEPTH];
    logic                       ack_q;
    logic                       wr_en;

    // first cycle of a request only
    assign wr_en = wr.req && !ack_q;

    // ack trails req by one cycle in both directions
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETn) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= wr.req;
        end
    end

    assign wr.ack = ack_q;

    // byte lanes written per strobe bit
    always_ff @(posedge S_AXI_ACLK) begin
        if (wr_en) begin
            for (int b = 0; b < frb_pkg::STRB_W; b++) begin
                if (wr.strb[b]) begin
                    mem[wr.addr][8*b +: 8] <= wr.data[8*b +: 8];
                end
            end
        end
    end

    // registered read, one cycle latency
    always_ff @(posedge S_AXI_ACLK) begin
        rd_data <= mem[rd_addr];
    end

    // the slave holds req until ack is up
    a_req_held_until_ack : assert property (
        @(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETn)
        $fell(wr.req) |-> $past(wr.ack)
    );

endmodule

`default_nettype wire

/* src/pulse_shaper.sv */
`default_nettype none

module pulse_shaper (
    input  logic                       S_AXI_ACLK,
    input  logic                       S_AXI_ARESETn,
    input  logic                       rst_frb,
    input  logic                       fire,
    input  logic [frb_pkg::DATA_W-1:0] pulse_width,
    output logic [15:0]                dac_out
);

    logic                       active_q;
    logic [frb_pkg::DATA_W-1:0] width_cnt_q;

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETn || rst_frb) begin
            active_q    <= 1'b0;
            width_cnt_q <= '0;
        end else if (fire) begin
            // a new event restarts the width even mid-pulse
            active_q    <= 1'b1;
            width_cnt_q <= '0;
        end else if (active_q) begin
            if (width_cnt_q == pulse_width) begin
                active_q    <= 1'b0;
                width_cnt_q <= '0;
            end else begin
                width_cnt_q <= width_cnt_q + 1'b1;
            end
        end
    end

    // high for pulse_width+1 cycles
    assign dac_out = active_q ? frb_pkg::PULSE_LEVEL : frb_pkg::IDLE_LEVEL;

endmodule

`default_nettype wire

/* tb.f */
src/frb_pkg.sv
src/frb_wr_if.sv
src/axil_wr_slave.sv
src/period_mem.sv
src/burst_sequencer.sv
src/pulse_shaper.sv
src/frb_trigger_top.sv
verif/frb_checker.sv
verif/tb_frb_trigger.sv

/* verif/frb_checker.sv */
`default_nettype none

module frb_checker #(
    parameter int MEM_DEPTH = 16,
    parameter int ADDR_W    = 7
) (
    input  logic                       S_AXI_ACLK,
    input  logic                       S_AXI_ARESETn,
    input  logic [ADDR_W-1:0]          S_AXI_AWADDR,
    input  logic                       S_AXI_AWVALID,
    input  logic                       S_AXI_AWREADY,
    input  logic [frb_pkg::DATA_W-1:0] S_AXI_WDATA,
    input  logic [frb_pkg::STRB_W-1:0] S_AXI_WSTRB,
    input  logic                       S_AXI_WREADY,
    input  logic [1:0]                 S_AXI_BRESP,
    input  logic                       S_AXI_BVALID,
    input  logic                       S_AXI_BREADY,
    input  logic [frb_pkg::DATA_W-1:0] pulse_width,
    input  logic                       rst_frb,
    input  logic [15:0]                dac_out,
    input  logic                       frb_done,
    // expected response of the write in flight
    input  frb_pkg::axi_resp_e         exp_resp,
    input  logic                       report,
    output int                         err_count,
    output int                         test_count
);

    // shadow copy of the period table
    logic [frb_pkg::DATA_W-1:0] shadow [MEM_DEPTH];
    logic [frb_pkg::DATA_W-1:0] wr_data;
    logic [frb_pkg::STRB_W-1:0] wr_strb;
    frb_pkg::axi_resp_e         wr_exp;
    int                         wr_idx;
    int                         cyc = 0;
    int                         last_rise = 0;
    int                         high_cnt = 0;
    int                         pulses = 0;
    int                         failed = 0;
    int                         errs_before = 0;
    int                         acc_cyc = 0;
    int                         b_lat = 0;
    logic                       busy = 1'b0;
    logic                       b_due = 1'b0;
    logic                       was_high = 1'b0;
    logic                       was_done = 1'b0;
    logic                       clear_due = 1'b0;
    logic                       summary_done = 1'b0;

    initial begin
        err_count  = 0;
        test_count = 0;
    end

    task automatic flag_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        err_count++;
        $display("FAILED time %0t signal %s got %0d expected %0d", $time, name, got, exp);
    endtask

    task automatic close_test(input string what);
        test_count++;
        if (err_count != errs_before) begin
            failed++;
        end
        $display("%s: %s", what, (err_count == errs_before) ? "ok" : "FAILED");
        errs_before = err_count;
    endtask

    always @(posedge S_AXI_ACLK) begin
        cyc++;
        if (S_AXI_ARESETn) begin
            // readies stay low from acceptance until the cycle after the B handshake
            if (S_AXI_AWREADY !== !busy) begin
                flag_mismatch("S_AXI_AWREADY", S_AXI_AWREADY, !busy);
            end
            if (S_AXI_WREADY !== !busy) begin
                flag_mismatch("S_AXI_WREADY", S_AXI_WREADY, !busy);
            end

            // address and data are taken in the same cycle
            if (S_AXI_AWVALID && S_AXI_AWREADY) begin
                wr_idx  = S_AXI_AWADDR >> 2;
                wr_data = S_AXI_WDATA;
                wr_strb = S_AXI_WSTRB;
                wr_exp  = exp_resp;
                acc_cyc = cyc;
                busy    = 1'b1;
                b_due   = 1'b1;
            end

            // BVALID 5 cycles after acceptance, 1 for a refused address
            if (b_due && S_AXI_BVALID === 1'b1) begin
                b_lat = (wr_exp == frb_pkg::OKAY) ? 5 : 1;
                if (cyc - acc_cyc != b_lat) begin
                    flag_mismatch("S_AXI_BVALID latency", cyc - acc_cyc, b_lat);
                end
                b_due = 1'b0;
            end else if (!busy && S_AXI_BVALID !== 1'b0) begin
                flag_mismatch("S_AXI_BVALID", S_AXI_BVALID, 0);
            end

            if (S_AXI_BVALID && S_AXI_BREADY) begin
                if (S_AXI_BRESP !== wr_exp) begin
                    flag_mismatch("S_AXI_BRESP", S_AXI_BRESP, wr_exp);
                end
                if (S_AXI_BRESP === frb_pkg::OKAY && wr_idx < MEM_DEPTH) begin
                    for (int b = 0; b < frb_pkg::STRB_W; b++) begin
                        if (wr_strb[b]) begin
                            shadow[wr_idx][8*b +: 8] = wr_data[8*b +: 8];
                        end
                    end
                end
                busy = 1'b0;
                close_test($sformatf("write word %0d resp %0d", wr_idx, S_AXI_BRESP));
            end

            // one cycle after rst_frb both outputs must be idle
            if (clear_due && frb_done !== 1'b0) begin
                flag_mismatch("frb_done", frb_done, 0);
            end
            if (clear_due && dac_out !== frb_pkg::IDLE_LEVEL) begin
                flag_mismatch("dac_out", dac_out, frb_pkg::IDLE_LEVEL);
            end
            clear_due = rst_frb;
            if (rst_frb) begin
                pulses = 0;
            end

            if (dac_out !== frb_pkg::PULSE_LEVEL && dac_out !== frb_pkg::IDLE_LEVEL) begin
                flag_mismatch("dac_out", dac_out, frb_pkg::IDLE_LEVEL);
            end
            if (dac_out === frb_pkg::PULSE_LEVEL && !was_high) begin
                if (pulses >= MEM_DEPTH) begin
                    $display("pulse %0d at time %0t lies past the end of the table", pulses, $time);
                    err_count++;
                end else if (pulses > 0 && cyc - last_rise != shadow[pulses] + 1) begin
                    flag_mismatch("dac_out spacing", cyc - last_rise, shadow[pulses] + 1);
                end
                pulses++;
                last_rise = cyc;
                high_cnt  = 0;
            end
            if (dac_out === frb_pkg::PULSE_LEVEL) begin
                high_cnt++;
            end else if (was_high) begin
                if (high_cnt != pulse_width + 1) begin
                    flag_mismatch("dac_out width", high_cnt, pulse_width + 1);
                end
                // the last pulse closes the run
                if (pulses == MEM_DEPTH) begin
                    if (frb_done !== 1'b1) begin
                        flag_mismatch("frb_done", frb_done, 1);
                    end
                    close_test($sformatf("run with %0d pulses", pulses));
                end
            end
            if (frb_done === 1'b1 && !was_done && pulses != MEM_DEPTH) begin
                flag_mismatch("dac_out pulse count", pulses, MEM_DEPTH);
            end
            was_high = (dac_out === frb_pkg::PULSE_LEVEL);
            was_done = (frb_done === 1'b1);
        end
        if (report && !summary_done) begin
            summary_done = 1'b1;
            $display("%0d tests, %0d failed, %0d errors", test_count, failed, err_count);
        end
    end

endmodule

`default_nettype wire

/* verif/tb_frb_trigger.sv */
`default_nettype none

module tb_frb_trigger;

    localparam int MEM_DEPTH = 16;
    localparam int ADDR_W    = $clog2(MEM_DEPTH) + 3;
    localparam int NUM_ROWS  = MEM_DEPTH + 5;
    // below the shortest period of 2
    localparam int PULSE_W   = 1;

    // one row per table write or per run command
    typedef struct packed {
        logic [ADDR_W-1:0]  addr;
        logic [31:0]        data;
        logic [3:0]         strb;
        frb_pkg::axi_resp_e resp;
        logic               is_run;
    } row_t;

    logic S_AXI_ACLK, S_AXI_ARESETn, S_AXI_AWVALID, S_AXI_AWREADY, S_AXI_WVALID;
    logic S_AXI_WREADY, S_AXI_BVALID, S_AXI_BREADY, en_frb, rst_frb, frb_done, report;
    logic [ADDR_W-1:0]          S_AXI_AWADDR;
    logic [2:0]                 S_AXI_AWPROT;
    logic [frb_pkg::DATA_W-1:0] S_AXI_WDATA, pulse_width;
    logic [frb_pkg::STRB_W-1:0] S_AXI_WSTRB;
    logic [1:0]                 S_AXI_BRESP;
    logic [15:0]                dac_out;
    frb_pkg::axi_resp_e         exp_resp;
    int                         err_count, test_count, limit;
    logic [31:0]                rng;
    row_t                       rows [NUM_ROWS];

    frb_trigger_top #(.MEM_DEPTH(MEM_DEPTH), .ADDR_W(ADDR_W)) i_frb_trigger_top (.*);
    frb_checker #(.MEM_DEPTH(MEM_DEPTH), .ADDR_W(ADDR_W)) i_frb_checker (.*);

    initial begin
        S_AXI_ACLK = 1'b0;
        forever #50 S_AXI_ACLK = ~S_AXI_ACLK;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic build_table();
        logic [31:0] period [MEM_DEPTH];
        for (int k = 0; k < MEM_DEPTH; k++) begin
            rng       = xorshift32(rng);
            period[k] = 2 + rng % 39;
            rows[k]   = {ADDR_W'(4 * k), period[k], 4'hF, frb_pkg::OKAY, 1'b0};
        end
        // out of range words, low bits alias entries 3 and 15
        rows[MEM_DEPTH]     = {ADDR_W'(4 * (MEM_DEPTH + 3)), 32'hFF, 4'hF, frb_pkg::SLVERR, 1'b0};
        rows[MEM_DEPTH + 1] = {ADDR_W'(8 * MEM_DEPTH - 4), 32'h77, 4'hF, frb_pkg::SLVERR, 1'b0};
        rows[MEM_DEPTH + 2] = {ADDR_W'(0), 32'h0, 4'h0, frb_pkg::OKAY, 1'b1};
        // 16 reset cycles, 10 per write, 200 spare
        limit = 16 + 10 * (MEM_DEPTH + 3) + 200;
        for (int k = 0; k < MEM_DEPTH; k++) begin
            limit += period[k] + 1;
        end
        // low byte of entry 5 only, upper lanes carry junk
        rng            = xorshift32(rng);
        period[5][7:0] = 8'(2 + rng % 39);
        rows[MEM_DEPTH + 3] = {ADDR_W'(20), {24'hC3C3C3, period[5][7:0]}, 4'b0001,
                               frb_pkg::OKAY, 1'b0};
        rows[MEM_DEPTH + 4] = {ADDR_W'(0), 32'h0, 4'h0, frb_pkg::OKAY, 1'b1};
        for (int k = 0; k < MEM_DEPTH; k++) begin
            limit += period[k] + 1;
        end
    endtask

    task automatic axi_write(input row_t row);
        int stall;
        rng   = xorshift32(rng);
        stall = int'(rng % 9);
        S_AXI_AWADDR  <= row.addr;
        S_AXI_WDATA   <= row.data;
        S_AXI_WSTRB   <= row.strb;
        exp_resp      <= row.resp;
        S_AXI_AWVALID <= 1'b1;
        S_AXI_WVALID  <= 1'b1;
        do begin
            @(posedge S_AXI_ACLK);
        end while (!S_AXI_AWREADY);
        S_AXI_AWVALID <= 1'b0;
        S_AXI_WVALID  <= 1'b0;
        // back-pressure on B
        repeat (stall) @(posedge S_AXI_ACLK);
        S_AXI_BREADY <= 1'b1;
        do begin
            @(posedge S_AXI_ACLK);
        end while (!S_AXI_BVALID);
        S_AXI_BREADY <= 1'b0;
    endtask

    task automatic run_table();
        rst_frb <= 1'b1;
        @(posedge S_AXI_ACLK);
        rst_frb <= 1'b0;
        en_frb  <= 1'b1;
        do begin
            @(posedge S_AXI_ACLK);
        end while (!frb_done);
        // let the last pulse finish
        repeat (PULSE_W + 3) @(posedge S_AXI_ACLK);
        en_frb <= 1'b0;
    endtask

    initial begin
        S_AXI_ARESETn = 1'b0;
        S_AXI_AWADDR  = '0;
        S_AXI_AWPROT  = 3'b000;
        S_AXI_AWVALID = 1'b0;
        S_AXI_WDATA   = '0;
        S_AXI_WSTRB   = '0;
        S_AXI_WVALID  = 1'b0;
        S_AXI_BREADY  = 1'b0;
        pulse_width   = PULSE_W;
        en_frb        = 1'b0;
        rst_frb       = 1'b0;
        exp_resp      = frb_pkg::OKAY;
        report        = 1'b0;
        rng           = 32'd93830;
        build_table();
        repeat (16) @(posedge S_AXI_ACLK);
        S_AXI_ARESETn <= 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (rows[r].is_run) begin
                run_table();
            end else begin
                axi_write(rows[r]);
            end
        end
        report <= 1'b1;
        repeat (2) @(posedge S_AXI_ACLK);
        if (err_count == 0 && test_count == NUM_ROWS) begin
            $display("Test OK");
        end else begin
            $display("%0d of %0d tests done, %0d errors", test_count, NUM_ROWS, err_count);
            $display("Test FAILED");
        end
        $finish;
    end

    // limit is set at time zero, read after the first edge
    initial begin
        int cycles;
        cycles = 0;
        @(posedge S_AXI_ACLK);
        while (cycles < limit) begin
            @(posedge S_AXI_ACLK);
            cycles++;
        end
        $display("timeout, the table did not finish within %0d cycles", limit);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire
